/* tile_pkg.sv */
// Single-beat messages only; address map assumes a 24-bit space with DRAM starting at 24'h80_0000
package tile_pkg;

  localparam int ADDR_W = 24;
  localparam int DATA_W = 64;
  localparam int TAG_W  = 4;
  localparam int DID_W  = 8;
  localparam int CORD_W = 8;
  localparam int HIO_W  = 8;

  localparam int NUM_DEV   = 3;
  localparam int DEV_IDX_W = 2;

  // Device order is {loopback, cfg, memory}
  localparam logic [DEV_IDX_W-1:0] DEV_MEM  = 2'd0;
  localparam logic [DEV_IDX_W-1:0] DEV_CFG  = 2'd1;
  localparam logic [DEV_IDX_W-1:0] DEV_LOOP = 2'd2;

  // Anything at or above this is non-local and goes to memory
  localparam logic [ADDR_W-1:0] DRAM_BASE = 24'h80_0000;

  localparam int DEV_FIELD_LSB = 19;
  localparam int DEV_FIELD_W   = 4;
  localparam logic [DEV_FIELD_W-1:0] CFG_DEV_ID   = 4'd2;
  localparam logic [DEV_FIELD_W-1:0] CACHE_DEV_ID = 4'd1;

  // Word offset within the address, shared by memory index and cfg offset
  localparam int WORD_LSB  = 3;
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);
  localparam int CFG_REG_W = 2;

  typedef enum logic {
    e_rd = 1'b0,
    e_wr = 1'b1
  } msg_type_e;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    msg_type_e         msg_type;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } cmd_msg_t;

  typedef struct packed {
    logic [TAG_W-1:0]     tag;
    msg_type_e            msg_type;
    logic [ADDR_W-1:0]    addr;
    logic [DEV_IDX_W-1:0] src_dev;
    logic [DATA_W-1:0]    data;
  } resp_msg_t;

  typedef struct packed {
    logic             freeze;
    logic [HIO_W-1:0] hio_mask;
  } cfg_bus_t;

endpackage

/* stream_buffer.sv */
// One entry only; full throughput relies on the consumer taking the item in the cycle it shows
`timescale 1ns/1ps

module stream_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     v_o,
  input  logic     ready_i
);

  logic     full_q;
  payload_t data_q;

  // Accept while empty or while the held item leaves
  assign ready_o = !full_q || ready_i;
  assign v_o     = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      data_q <= data_i;
    end
  end

endmodule

/* cmd_router.sv */
// Combinational steering only; the command payload fans out to every buffer at the top level
`timescale 1ns/1ps

module cmd_router (
  input  tile_pkg::cmd_msg_t           cmd_i,
  input  logic                         cmd_v_i,
  output logic                         cmd_ready_o,
  output logic [tile_pkg::NUM_DEV-1:0] dev_v_o,
  input  logic [tile_pkg::NUM_DEV-1:0] dev_ready_i
);

  import tile_pkg::*;

  logic                   is_local;
  logic [DEV_FIELD_W-1:0] dev_field;
  logic                   is_cfg;
  logic                   is_mem;
  logic [DEV_IDX_W-1:0]   dst;

  assign is_local  = (cmd_i.addr < DRAM_BASE);
  assign dev_field = cmd_i.addr[DEV_FIELD_LSB +: DEV_FIELD_W];
  assign is_cfg    = is_local && (dev_field == CFG_DEV_ID);
  // Non-local addresses always land in memory
  assign is_mem    = !is_local || (dev_field == CACHE_DEV_ID);

  always_comb begin
    if (is_cfg) begin
      dst = DEV_CFG;
    end else if (is_mem) begin
      dst = DEV_MEM;
    end else begin
      dst = DEV_LOOP;
    end
  end

  always_comb begin
    dev_v_o      = '0;
    dev_v_o[dst] = cmd_v_i;
  end

  // Only the chosen buffer can stall the command
  assign cmd_ready_o = dev_ready_i[dst];

endmodule

/* cfg_regs.sv */
// Four registers at word offsets 0..3; id and coordinate are read-only, writes to them are dropped
`timescale 1ns/1ps

module cfg_regs (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  tile_pkg::cmd_msg_t           cmd_i,
  input  logic                         cmd_v_i,
  output logic                         cmd_ready_o,
  output tile_pkg::resp_msg_t          resp_o,
  output logic                         resp_v_o,
  input  logic                         resp_ready_i,
  input  logic [tile_pkg::DID_W-1:0]   did_i,
  input  logic [tile_pkg::CORD_W-1:0]  cord_i,
  output tile_pkg::cfg_bus_t           cfg_bus_o
);

  import tile_pkg::*;

  logic [CFG_REG_W-1:0] reg_ofs;
  logic                 cmd_fire;
  logic                 is_wr;
  logic [DATA_W-1:0]    rd_data;
  logic                 freeze_q;
  logic [HIO_W-1:0]     hio_mask_q;
  logic                 resp_v_q;
  resp_msg_t            resp_q;

  assign reg_ofs     = cmd_i.addr[WORD_LSB +: CFG_REG_W];
  assign is_wr       = (cmd_i.msg_type == e_wr);
  assign cmd_ready_o = !resp_v_q || resp_ready_i;
  assign cmd_fire    = cmd_v_i && cmd_ready_o;

  always_comb begin
    case (reg_ofs)
      2'd0:    rd_data = DATA_W'(did_i);
      2'd1:    rd_data = DATA_W'(cord_i);
      2'd2:    rd_data = DATA_W'(freeze_q);
      default: rd_data = DATA_W'(hio_mask_q);
    endcase
  end

  // Tile comes up frozen with all hio masked off
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      freeze_q   <= 1'b1;
      hio_mask_q <= '0;
    end else if (cmd_fire && is_wr) begin
      if (reg_ofs == 2'd2) begin
        freeze_q <= cmd_i.data[0];
      end
      if (reg_ofs == 2'd3) begin
        hio_mask_q <= cmd_i.data[HIO_W-1:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_v_q <= 1'b0;
    end else if (cmd_fire) begin
      resp_v_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      resp_q <= '{tag: cmd_i.tag, msg_type: cmd_i.msg_type, addr: cmd_i.addr,
                  src_dev: '0, data: (is_wr ? '0 : rd_data)};
    end
  end

  assign resp_o    = resp_q;
  assign resp_v_o  = resp_v_q;
  assign cfg_bus_o = '{freeze: freeze_q, hio_mask: hio_mask_q};

endmodule

/* loopback_dev.sv */
// Acks every command with zero data; address and data are not checked
`timescale 1ns/1ps

module loopback_dev (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  tile_pkg::cmd_msg_t  cmd_i,
  input  logic                cmd_v_i,
  output logic                cmd_ready_o,
  output tile_pkg::resp_msg_t resp_o,
  output logic                resp_v_o,
  input  logic                resp_ready_i
);

  import tile_pkg::*;

  logic      resp_v_q;
  resp_msg_t resp_q;
  logic      cmd_fire;

  assign cmd_ready_o = !resp_v_q || resp_ready_i;
  assign cmd_fire    = cmd_v_i && cmd_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_v_q <= 1'b0;
    end else if (cmd_fire) begin
      resp_v_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_q <= 1'b0;
    end
  end

  // Header echoed as is
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      resp_q <= '{tag: cmd_i.tag, msg_type: cmd_i.msg_type, addr: cmd_i.addr,
                  src_dev: '0, data: '0};
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

endmodule

/* backing_mem.sv */
// 256 words indexed by addr[10:3]; upper address bits alias, contents power up undefined
`timescale 1ns/1ps

module backing_mem (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  tile_pkg::cmd_msg_t  cmd_i,
  input  logic                cmd_v_i,
  output logic                cmd_ready_o,
  output tile_pkg::resp_msg_t resp_o,
  output logic                resp_v_o,
  input  logic                resp_ready_i
);

  import tile_pkg::*;

  logic [DATA_W-1:0]    mem_q [MEM_WORDS];
  logic [MEM_IDX_W-1:0] idx;
  logic                 is_wr;
  logic                 cmd_fire;
  logic [DATA_W-1:0]    rsp_data;
  logic                 resp_v_q;
  resp_msg_t            resp_q;

  assign idx         = cmd_i.addr[WORD_LSB +: MEM_IDX_W];
  assign is_wr       = (cmd_i.msg_type == e_wr);
  assign cmd_ready_o = !resp_v_q || resp_ready_i;
  assign cmd_fire    = cmd_v_i && cmd_ready_o;
  assign rsp_data    = is_wr ? '0 : mem_q[idx];

  always_ff @(posedge clk_i) begin
    if (cmd_fire && is_wr) begin
      mem_q[idx] <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_v_q <= 1'b0;
    end else if (cmd_fire) begin
      resp_v_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_q <= 1'b0;
    end
  end

  // Read data is captured straight into the response slot
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      resp_q <= '{tag: cmd_i.tag, msg_type: cmd_i.msg_type, addr: cmd_i.addr,
                  src_dev: '0, data: rsp_data};
    end
  end

  assign resp_o   = resp_q;
  assign resp_v_o = resp_v_q;

endmodule

/* resp_arbiter.sv */
// Round-robin over NUM_DEV sources; response order across devices is not kept, use the tag
`timescale 1ns/1ps

module resp_arbiter (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  tile_pkg::resp_msg_t [tile_pkg::NUM_DEV-1:0] dev_resp_i,
  input  logic [tile_pkg::NUM_DEV-1:0]              dev_v_i,
  output logic [tile_pkg::NUM_DEV-1:0]              dev_ready_o,
  output tile_pkg::resp_msg_t                       resp_o,
  output logic                                      resp_v_o,
  input  logic                                      resp_ready_i
);

  import tile_pkg::*;

  logic [DEV_IDX_W-1:0] rr_q;
  logic [DEV_IDX_W-1:0] grant_idx;
  logic                 found;
  logic                 buf_ready;
  resp_msg_t            arb_resp;

  // First valid source at or after the pointer
  always_comb begin : grant_search
    int unsigned idx;
    found     = 1'b0;
    grant_idx = '0;
    for (int i = 0; i < NUM_DEV; i++) begin
      idx = (int'(rr_q) + i) % NUM_DEV;
      if (!found && dev_v_i[idx]) begin
        found     = 1'b1;
        grant_idx = DEV_IDX_W'(idx);
      end
    end
  end

  always_comb begin
    dev_ready_o = '0;
    dev_ready_o[grant_idx] = found && buf_ready;
    arb_resp         = dev_resp_i[grant_idx];
    arb_resp.src_dev = grant_idx;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (found && buf_ready) begin
      rr_q <= (grant_idx == DEV_IDX_W'(NUM_DEV - 1)) ? '0 : grant_idx + 1'b1;
    end
  end

  stream_buffer #(.payload_t(resp_msg_t)) u_out_buf (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .data_i (arb_resp),
    .v_i    (found),
    .ready_o(buf_ready),
    .data_o (resp_o),
    .v_o    (resp_v_o),
    .ready_i(resp_ready_i)
  );

endmodule

/* l2e_tile.sv */
// Single command stream in, single response stream out; at least 3 cycles from command to response
`timescale 1ns/1ps

module l2e_tile (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [tile_pkg::DID_W-1:0]    my_did_i,
  input  logic [tile_pkg::CORD_W-1:0]   my_cord_i,
  input  tile_pkg::cmd_msg_t            cmd_i,
  input  logic                          cmd_v_i,
  output logic                          cmd_ready_o,
  output tile_pkg::resp_msg_t           resp_o,
  output logic                          resp_v_o,
  input  logic                          resp_ready_i,
  output tile_pkg::cfg_bus_t            cfg_bus_o
);

  import tile_pkg::*;

  logic [NUM_DEV-1:0]      route_v;
  logic [NUM_DEV-1:0]      route_ready;
  cmd_msg_t [NUM_DEV-1:0]  dev_cmd;
  logic [NUM_DEV-1:0]      dev_cmd_v;
  logic [NUM_DEV-1:0]      dev_cmd_ready;
  resp_msg_t [NUM_DEV-1:0] dev_resp;
  logic [NUM_DEV-1:0]      dev_resp_v;
  logic [NUM_DEV-1:0]      dev_resp_ready;

  cmd_router u_cmd_router (
    .cmd_i      (cmd_i),
    .cmd_v_i    (cmd_v_i),
    .cmd_ready_o(cmd_ready_o),
    .dev_v_o    (route_v),
    .dev_ready_i(route_ready)
  );

  // One buffer per device so a full device never blocks the others
  for (genvar i = 0; i < NUM_DEV; i++) begin : g_cmd_buf
    stream_buffer #(.payload_t(cmd_msg_t)) u_cmd_buf (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .data_i (cmd_i),
      .v_i    (route_v[i]),
      .ready_o(route_ready[i]),
      .data_o (dev_cmd[i]),
      .v_o    (dev_cmd_v[i]),
      .ready_i(dev_cmd_ready[i])
    );
  end

  backing_mem u_backing_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (dev_cmd[DEV_MEM]),
    .cmd_v_i     (dev_cmd_v[DEV_MEM]),
    .cmd_ready_o (dev_cmd_ready[DEV_MEM]),
    .resp_o      (dev_resp[DEV_MEM]),
    .resp_v_o    (dev_resp_v[DEV_MEM]),
    .resp_ready_i(dev_resp_ready[DEV_MEM])
  );

  cfg_regs u_cfg_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (dev_cmd[DEV_CFG]),
    .cmd_v_i     (dev_cmd_v[DEV_CFG]),
    .cmd_ready_o (dev_cmd_ready[DEV_CFG]),
    .resp_o      (dev_resp[DEV_CFG]),
    .resp_v_o    (dev_resp_v[DEV_CFG]),
    .resp_ready_i(dev_resp_ready[DEV_CFG]),
    .did_i       (my_did_i),
    .cord_i      (my_cord_i),
    .cfg_bus_o   (cfg_bus_o)
  );

  loopback_dev u_loopback_dev (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (dev_cmd[DEV_LOOP]),
    .cmd_v_i     (dev_cmd_v[DEV_LOOP]),
    .cmd_ready_o (dev_cmd_ready[DEV_LOOP]),
    .resp_o      (dev_resp[DEV_LOOP]),
    .resp_v_o    (dev_resp_v[DEV_LOOP]),
    .resp_ready_i(dev_resp_ready[DEV_LOOP])
  );

  resp_arbiter u_resp_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dev_resp_i  (dev_resp),
    .dev_v_i     (dev_resp_v),
    .dev_ready_o (dev_resp_ready),
    .resp_o      (resp_o),
    .resp_v_o    (resp_v_o),
    .resp_ready_i(resp_ready_i)
  );

endmodule

/* tb_l2e_tile.sv */
// Fixed seed; memory reads only target written words, so backing memory contents stay defined
`timescale 1ns/1ps

module tb_l2e_tile;

  import tile_pkg::*;

  localparam int          CLK_PERIOD  = 8;
  localparam logic [31:0] SEED        = 32'h5923ccb3;
  localparam int          N_CFG       = 10;
  localparam int          N_MEM       = 60;
  localparam int          N_LOOP      = 30;
  localparam int          N_MIX       = 200;
  localparam int          N_CMDS      = N_CFG + N_MEM + N_LOOP + N_MIX;
  localparam int          TIMEOUT_CYC = N_CMDS * 40 + 400;
  localparam int          DRAIN_LIMIT = 200;

  logic                clk_i;
  logic                rst_n_i;
  logic [DID_W-1:0]    my_did_i;
  logic [CORD_W-1:0]   my_cord_i;
  cmd_msg_t            cmd_i;
  logic                cmd_v_i;
  logic                cmd_ready_o;
  resp_msg_t           resp_o;
  logic                resp_v_o;
  logic                resp_ready_i;
  cfg_bus_t            cfg_bus_o;

  logic [31:0] seed;
  logic [31:0] bp_seed;
  logic        bp_en;
  int          errors;
  int          checks;
  int          test_err;
  int          outstanding;
  logic [3:0]  next_tag;

  // Reference model state
  logic [DATA_W-1:0] m_mem [MEM_WORDS];
  bit                written [MEM_WORDS];
  logic [7:0]        wr_idx_q [$];
  logic              m_freeze;
  logic [7:0]        m_hio;
  resp_msg_t         exp_q [16];
  bit                exp_pend [16];

  l2e_tile u_l2e_tile (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .my_did_i    (my_did_i),
    .my_cord_i   (my_cord_i),
    .cmd_i       (cmd_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_ready_o (cmd_ready_o),
    .resp_o      (resp_o),
    .resp_v_o    (resp_v_o),
    .resp_ready_i(resp_ready_i),
    .cfg_bus_o   (cfg_bus_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Applies a command to the model and returns the response the tile must give
  function automatic resp_msg_t model_apply(input cmd_msg_t c);
    resp_msg_t  r;
    logic [3:0] fld;
    logic [7:0] idx;
    fld = c.addr[22:19];
    idx = c.addr[10:3];
    r = '{tag: c.tag, msg_type: c.msg_type, addr: c.addr, src_dev: DEV_LOOP, data: '0};
    if (!c.addr[23] && fld == 4'd2) begin
      r.src_dev = DEV_CFG;
      if (c.msg_type == e_wr) begin
        if (c.addr[4:3] == 2'd2) m_freeze = c.data[0];
        if (c.addr[4:3] == 2'd3) m_hio = c.data[7:0];
      end else begin
        case (c.addr[4:3])
          2'd0:    r.data = 64'(my_did_i);
          2'd1:    r.data = 64'(my_cord_i);
          2'd2:    r.data = 64'(m_freeze);
          default: r.data = 64'(m_hio);
        endcase
      end
    end else if (c.addr[23] || fld == 4'd1) begin
      r.src_dev = DEV_MEM;
      if (c.msg_type == e_wr) begin
        m_mem[idx] = c.data;
        if (!written[idx]) wr_idx_q.push_back(idx);
        written[idx] = 1'b1;
      end else begin
        r.data = m_mem[idx];
      end
    end
    return r;
  endfunction

  // Non-local or local cache field picked at random
  function automatic logic [23:0] mem_addr(input logic [7:0] idx);
    logic [31:0] r;
    r = $random(seed);
    if (r[31]) return {1'b1, r[11:0], idx, 3'b000};
    return {1'b0, 4'd1, r[7:0], idx, 3'b000};
  endfunction

  function automatic logic [23:0] cfg_addr(input logic [1:0] ofs);
    logic [31:0] r;
    r = $random(seed);
    return {1'b0, 4'd2, r[13:0], ofs, 3'b000};
  endfunction

  // Low byte differs from both freeze and hio so any stray or missing write shows on the bus
  function automatic logic [63:0] cfg_flip_data();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo[31:8], ~m_hio[7:1], !m_freeze};
  endfunction

  function automatic logic [23:0] loop_addr();
    logic [31:0] r;
    logic [3:0]  fld;
    r   = $random(seed);
    fld = r[23:20];
    if (fld == 4'd1 || fld == 4'd2) fld = fld + 4'd2;
    return {1'b0, fld, r[18:0]};
  endfunction

  task automatic check_resp(input resp_msg_t got);
    checks++;
    if (!exp_pend[got.tag]) begin
      $display("unexpected response with tag %0d at %0t ns", got.tag, $time);
      errors++;
    end else begin
      if (got !== exp_q[got.tag]) begin
        $display("[FAIL] %0t ns tag %0d response got %h expected %h",
                 $time, got.tag, got, exp_q[got.tag]);
        errors++;
      end
      exp_pend[got.tag] = 1'b0;
      outstanding--;
    end
  endtask

  task automatic check_cfg(input cfg_bus_t got, input cfg_bus_t exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %0t ns cfg bus got %h expected %h", $time, got, exp);
      errors++;
    end
  endtask

  // Called 1 ns after a rising edge; returns at the same phase once accepted
  task automatic send_cmd(input msg_type_e t, input logic [23:0] a, input logic [63:0] d);
    cmd_msg_t c;
    while (exp_pend[next_tag] || outstanding >= 15) begin
      @(posedge clk_i);
      #1;
    end
    c = '{tag: next_tag, msg_type: t, addr: a, data: d};
    exp_q[next_tag]    = model_apply(c);
    exp_pend[next_tag] = 1'b1;
    outstanding++;
    next_tag++;
    cmd_i   = c;
    cmd_v_i = 1'b1;
    do @(negedge clk_i); while (!cmd_ready_o);
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
  endtask

  task automatic drain();
    int cyc;
    cyc = 0;
    while (outstanding != 0 && cyc < DRAIN_LIMIT) begin
      @(posedge clk_i);
      #1;
      cyc++;
    end
    if (outstanding != 0) begin
      $display("missing responses: %0d commands never answered at %0t ns", outstanding, $time);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s finished with %0d errors", name, errors - test_err);
    test_err = errors;
  endtask

  task automatic random_cmd(input int kind);
    logic [31:0] r;
    r = $random(seed);
    case (kind)
      0: send_cmd(e_wr, mem_addr(r[7:0]), {$random(seed), $random(seed)});
      1: begin
        if (wr_idx_q.size() == 0) send_cmd(e_wr, mem_addr(r[7:0]), {$random(seed), r});
        else send_cmd(e_rd, mem_addr(wr_idx_q[r[30:8] % wr_idx_q.size()]), '0);
      end
      2: send_cmd(r[31] ? e_wr : e_rd, cfg_addr(r[1:0]), {$random(seed), $random(seed)});
      default: send_cmd(r[31] ? e_wr : e_rd, loop_addr(), {$random(seed), r});
    endcase
  endtask

  // Response monitor samples mid-cycle where outputs are settled
  initial begin : resp_monitor
    resp_msg_t held;
    logic      held_v;
    held_v = 1'b0;
    forever begin
      @(negedge clk_i);
      if (held_v && (resp_v_o !== 1'b1 || resp_o !== held)) begin
        $display("[FAIL] %0t ns stalled response dropped or changed", $time);
        errors++;
      end
      if (resp_v_o && resp_ready_i) check_resp(resp_o);
      held_v = resp_v_o && !resp_ready_i;
      held   = resp_o;
    end
  end

  initial begin : ready_driver
    logic [31:0] r;
    logic        nxt;
    forever begin
      @(posedge clk_i);
      r   = $random(bp_seed);
      nxt = bp_en ? r[0] : 1'b1;
      #1;
      resp_ready_i = nxt;
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("sim failed");
    $finish;
  end

  initial begin : main
    logic [31:0] r;
    seed         = SEED;
    bp_seed      = SEED ^ 32'h1;
    bp_en        = 1'b0;
    errors       = 0;
    checks       = 0;
    test_err     = 0;
    outstanding  = 0;
    next_tag     = '0;
    m_freeze     = 1'b1;
    m_hio        = '0;
    rst_n_i      = 1'b0;
    cmd_i        = '0;
    cmd_v_i      = 1'b0;
    resp_ready_i = 1'b1;
    r            = $random(seed);
    my_did_i     = r[7:0];
    my_cord_i    = r[15:8];
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    checks++;
    if (resp_v_o !== 1'b0) begin
      $display("[FAIL] %0t ns resp_v_o high after reset", $time);
      errors++;
    end
    check_cfg(cfg_bus_o, '{freeze: 1'b1, hio_mask: 8'h00});
    end_test("reset");

    send_cmd(e_wr, cfg_addr(2'd2), cfg_flip_data());
    send_cmd(e_wr, cfg_addr(2'd3), cfg_flip_data());
    drain();
    check_cfg(cfg_bus_o, '{freeze: m_freeze, hio_mask: m_hio});
    for (int i = 0; i < 4; i++) send_cmd(e_rd, cfg_addr(2'(i)), '0);
    send_cmd(e_wr, cfg_addr(2'd0), cfg_flip_data());
    send_cmd(e_wr, cfg_addr(2'd1), cfg_flip_data());
    send_cmd(e_rd, cfg_addr(2'd0), '0);
    send_cmd(e_rd, cfg_addr(2'd1), '0);
    drain();
    check_cfg(cfg_bus_o, '{freeze: m_freeze, hio_mask: m_hio});
    end_test("config registers");

    for (int i = 0; i < N_MEM; i++) random_cmd(i < 8 ? 0 : ($random(seed) & 1));
    drain();
    end_test("memory path");

    for (int i = 0; i < N_LOOP; i++) random_cmd(3);
    drain();
    end_test("loopback");

    bp_en = 1'b1;
    for (int i = 0; i < N_MIX; i++) random_cmd($random(seed) & 3);
    drain();
    bp_en = 1'b0;
    check_cfg(cfg_bus_o, '{freeze: m_freeze, hio_mask: m_hio});
    end_test("mixed traffic with back-pressure");

    $display("done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* compile.f */
tile_pkg.sv
stream_buffer.sv
cmd_router.sv
cfg_regs.sv
loopback_dev.sv
backing_mem.sv
resp_arbiter.sv
l2e_tile.sv
tb_l2e_tile.sv
